/* design/astro_cfg.svh */
//============================
// Board-level constants for the Astrocade player I/O
// Host download indexes, DIP bank size, idle row value
// Screen edge limits and the interlace line fold
//============================

`ifndef ASTRO_CFG_SVH
`define ASTRO_CFG_SVH

//============================
// Host configuration indexes
//============================
// Game select byte
`define ASTRO_IDX_GAME 8'd1
// DIP switch bytes, one per address
`define ASTRO_IDX_DIP 8'd254
`define ASTRO_DIP_BANKS 8

// Switch matrix answer when nothing is selected
`define ASTRO_ROW_IDLE 8'hff

// Raw joystick word from the host
`define ASTRO_JOY_BITS 16

//============================
// Video geometry
//============================
// Second field starts here in the interlaced count
`define ASTRO_LINE_FOLD 11'd264
`define ASTRO_LINE_SUB 11'd263
// Blank at or above the bottom line, at or below the top line
`define ASTRO_VTOP 11'd21
`define ASTRO_VBOT 11'd260
// Left edge, blank at or below this pixel
`define ASTRO_HLEFT 9'd70

`endif

/* design/astro_pkg.sv */
//============================
// Shared types for the player I/O glue
// Game codes, button groups, keyboard event, pixel
//============================

`include "astro_cfg.svh"

package astro_pkg;

	//============================
	// Game select
	//============================
	// Values follow the host's game codes
	typedef enum logic [2:0] {
		none       = 3'd0,
		space_zap  = 3'd3,
		wizard_wor = 3'd5,
		robby_roto = 3'd6
	} game_t;

	//============================
	// Buttons, all active high
	//============================
	// One player's stick and two fire buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
	} player_btn_t;

	// Cabinet buttons shared by both players
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} sys_btn_t;

	// Keyboard event from the host
	// Toggle flips once per event, code bit 8 marks an extended key
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// 4-bit per channel pixel
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

endpackage

/* design/astro_game_config.sv */
//============================
// Game select register and DIP switch bank
// Both loaded through the host configuration strobe
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_game_config (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            cfg_wr,
	input  logic [7:0]                      cfg_index,
	input  logic [2:0]                      cfg_addr,
	input  logic [7:0]                      cfg_data,
	output astro_pkg::game_t                game,
	output logic [8*`ASTRO_DIP_BANKS-1:0]   dip
);
	import astro_pkg::*;

	// Host code to game, unknown codes give none
	function automatic game_t decode_game(input logic [7:0] code);
		game_t sel;
		case (code)
			8'd3:    sel = space_zap;
			8'd5:    sel = wizard_wor;
			8'd6:    sel = robby_roto;
			default: sel = none;
		endcase
		return sel;
	endfunction

	// Write qualifiers
	logic game_wr;
	logic dip_wr;

	assign game_wr = cfg_wr && (cfg_index == `ASTRO_IDX_GAME);
	assign dip_wr  = cfg_wr && (cfg_index == `ASTRO_IDX_DIP);

	//============================
	// Registers
	//============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game <= none;
			dip  <= '0;
		end else begin
			// Game code takes effect on the write edge
			if (game_wr) begin
				game <= decode_game(cfg_data);
			end
			// Address picks the DIP byte
			if (dip_wr) begin
				dip[{cfg_addr, 3'b000} +: 8] <= cfg_data;
			end
		end
	end

endmodule

/* design/astro_key_capture.sv */
//============================
// Keyboard button latches for two players
// Merge with the joystick words into player buttons
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_key_capture (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  astro_pkg::ps2_key_t          ps2_key,
	input  logic [`ASTRO_JOY_BITS-1:0]   joy_p1,
	input  logic [`ASTRO_JOY_BITS-1:0]   joy_p2,
	output astro_pkg::player_btn_t       p1,
	output astro_pkg::player_btn_t       p2,
	output astro_pkg::sys_btn_t          sys
);
	import astro_pkg::*;

	// Joystick bits 0..5 are right, left, down, up, fire1, fire2
	function automatic player_btn_t joy_to_btn(input logic [`ASTRO_JOY_BITS-1:0] joy);
		player_btn_t btn;
		btn.up    = joy[3];
		btn.down  = joy[2];
		btn.left  = joy[1];
		btn.right = joy[0];
		btn.fire1 = joy[4];
		btn.fire2 = joy[5];
		return btn;
	endfunction

	logic        toggle_q;
	logic        key_event;
	player_btn_t key_p1;
	player_btn_t key_p2;
	sys_btn_t    key_sys;

	// Any flip of toggle is one new event
	assign key_event = ps2_key.toggle != toggle_q;

	//============================
	// Key latches
	//============================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			key_p1   <= '0;
			key_p2   <= '0;
			key_sys  <= '0;
		end else begin
			toggle_q <= ps2_key.toggle;
			if (key_event) begin
				case (ps2_key.code)
					// Extended arrow keys
					// Up also matches the plain code
					9'h075, 9'h175: key_p1.up    <= ps2_key.pressed;
					9'h172:         key_p1.down  <= ps2_key.pressed;
					9'h16b:         key_p1.left  <= ps2_key.pressed;
					9'h174:         key_p1.right <= ps2_key.pressed;
					// Ctrl and space
					9'h014:         key_p1.fire1 <= ps2_key.pressed;
					9'h029:         key_p1.fire2 <= ps2_key.pressed;
					// F1/F2/F3 or the MAME keys 1, 2, 5
					9'h005, 9'h016: key_sys.start1 <= ps2_key.pressed;
					9'h006, 9'h01e: key_sys.start2 <= ps2_key.pressed;
					9'h004, 9'h02e: key_sys.coin   <= ps2_key.pressed;
					// Player 2 on R F D G, A and S
					9'h02d:         key_p2.up    <= ps2_key.pressed;
					9'h02b:         key_p2.down  <= ps2_key.pressed;
					9'h023:         key_p2.left  <= ps2_key.pressed;
					9'h034:         key_p2.right <= ps2_key.pressed;
					9'h01c:         key_p2.fire1 <= ps2_key.pressed;
					9'h01b:         key_p2.fire2 <= ps2_key.pressed;
					default: ;
				endcase
			end
		end
	end

	//============================
	// Merge with joysticks
	//============================
	assign p1 = key_p1 | joy_to_btn(joy_p1);
	assign p2 = key_p2 | joy_to_btn(joy_p2);

	// Cabinet buttons live on player 1 bits 6..8
	assign sys = key_sys | {joy_p1[6], joy_p1[7], joy_p1[8]};

endmodule

/* design/astro_switch_matrix.sv */
//============================
// Switch matrix row answer per column strobe
// Game specific layouts, active low buttons
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_switch_matrix (
	input  logic [7:0]                      col_select,
	input  astro_pkg::game_t                game,
	input  logic [8*`ASTRO_DIP_BANKS-1:0]   dip,
	input  astro_pkg::player_btn_t          p1,
	input  astro_pkg::player_btn_t          p2,
	input  astro_pkg::sys_btn_t             sys,
	input  logic                            speech_busy,
	output logic [7:0]                      row_data
);
	import astro_pkg::*;

	// Low nibble shared by every stick column: right, left, down, up
	function automatic logic [3:0] stick_bits(input player_btn_t btn);
		return {~btn.right, ~btn.left, ~btn.down, ~btn.up};
	endfunction

	logic [7:0] dip_b2;
	logic [7:0] dip_b3;

	assign dip_b2 = dip[23:16];
	assign dip_b3 = dip[31:24];

	//============================
	// Row select
	//============================
	always_comb begin
		row_data = `ASTRO_ROW_IDLE;
		// Column 08 is DIP byte 3 on every kept game
		if (game != none && col_select == 8'h08) begin
			row_data = dip_b3;
		end
		case (game)
			space_zap: begin
				case (col_select)
					8'h01: row_data = {2'b11, ~sys.start2, ~sys.start1, dip_b2[1], 1'b1,
						~sys.coin, 1'b1};
					8'h02: row_data = {3'b111, ~p2.fire1, stick_bits(p2)};
					8'h04: row_data = {2'b11, dip_b2[0], ~p1.fire1, stick_bits(p1)};
					default: ;
				endcase
			end
			wizard_wor: begin
				// Fire2 reads uninverted on this board
				case (col_select)
					8'h01: row_data = {dip_b2[2], ~sys.start2, ~sys.start1, 1'b1, dip_b2[1],
						1'b1, ~sys.coin, 1'b1};
					8'h02: row_data = {2'b11, ~p2.fire1, p2.fire2, stick_bits(p2)};
					// Speech chip busy on bit 7
					8'h04: row_data = {speech_busy, 1'b1, ~p1.fire1, p1.fire2, stick_bits(p1)};
					default: ;
				endcase
			end
			robby_roto: begin
				case (col_select)
					8'h01: row_data = {1'b0, ~sys.start2, ~sys.start1, 1'b1, dip_b2[1], 1'b1,
						~sys.coin, 1'b1};
					8'h02: row_data = {2'b11, ~p2.fire1, 1'b1, stick_bits(p2)};
					8'h04: row_data = {2'b11, ~p1.fire1, 1'b1, stick_bits(p1)};
					default: ;
				endcase
			end
			default: ;
		endcase
	end

endmodule

/* design/astro_audio_mix.sv */
//============================
// Audio mixer, chip and speech samples
// Registered 16-bit left and right
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_audio_mix (
	input  logic              clk_sys,
	input  logic              reset,
	input  astro_pkg::game_t  game,
	input  logic [7:0]        chip_l,
	input  logic [7:0]        chip_r,
	input  logic [15:0]       sample_l,
	input  logic [15:0]       sample_r,
	output logic [15:0]       audio_l,
	output logic [15:0]       audio_r
);
	import astro_pkg::*;

	logic [15:0] wow_l;
	logic [15:0] wow_r;
	logic [15:0] mix_l;
	logic [15:0] mix_r;

	// Speech is loud, so it goes in at a quarter
	assign wow_l = {1'b0, chip_l, chip_l[7:2]} + {2'b00, sample_l[15:2]};
	assign wow_r = {1'b0, chip_r, chip_r[7:2]} + {2'b00, sample_r[15:2]};

	always_comb begin
		case (game)
			wizard_wor: begin
				mix_l = wow_l;
				mix_r = wow_r;
			end
			// Two sound chips, true stereo
			robby_roto: begin
				mix_l = {chip_l, chip_l};
				mix_r = {chip_r, chip_r};
			end
			// Single chip, mono on both sides
			default: begin
				mix_l = {chip_l, chip_l};
				mix_r = {chip_l, chip_l};
			end
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= mix_l;
			audio_r <= mix_r;
		end
	end

endmodule

/* design/astro_video_post.sv */
//============================
// Video post stage
// Line fold, edge blanking, Space Zap mono recolor
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_video_post (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  astro_pkg::game_t                game,
	input  logic [8*`ASTRO_DIP_BANKS-1:0]   dip,
	input  logic [8:0]                      hcount,
	input  logic [10:0]                     vcount,
	input  astro_pkg::rgb_t                 rgb_in,
	output astro_pkg::rgb_t                 rgb_out
);
	import astro_pkg::*;

	logic [10:0] line;
	logic        edge_blank;
	logic        mono;
	rgb_t        pix_next;

	// Second interlaced field maps back onto the first
	assign line = (vcount >= `ASTRO_LINE_FOLD) ? vcount - `ASTRO_LINE_SUB : vcount;

	assign edge_blank = (line >= `ASTRO_VBOT) || (line <= `ASTRO_VTOP) ||
		(hcount <= `ASTRO_HLEFT);

	// DIP byte 0 bit 1 selects mono
	assign mono = (game == space_zap) && dip[1];

	//============================
	// Pixel rules
	//============================
	always_comb begin
		pix_next = rgb_in;
		// Later match overrides earlier
		if (mono) begin
			if (rgb_in.g == 4'd15 && rgb_in.b == 4'd4) begin
				pix_next = '{r: 4'd14, g: 4'd14, b: 4'd14};
			end
			if (rgb_in.b == 4'd11) begin
				pix_next = '{r: 4'd10, g: 4'd10, b: 4'd10};
			end
			if (rgb_in.g == 4'd4) begin
				pix_next = '{r: 4'd8, g: 4'd8, b: 4'd8};
			end
		end
		// Edges always black
		if (edge_blank) begin
			pix_next = '0;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_out <= '0;
		end else begin
			rgb_out <= pix_next;
		end
	end

endmodule

/* design/astro_io_top.sv */
//============================
// Player I/O glue top level
// Config, keys, matrix, audio, video
//============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_io_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	// Host configuration strobe
	input  logic                         cfg_wr,
	input  logic [7:0]                   cfg_index,
	input  logic [2:0]                   cfg_addr,
	input  logic [7:0]                   cfg_data,
	// Player controls
	input  astro_pkg::ps2_key_t          ps2_key,
	input  logic [`ASTRO_JOY_BITS-1:0]   joy_p1,
	input  logic [`ASTRO_JOY_BITS-1:0]   joy_p2,
	// CPU switch matrix
	input  logic [7:0]                   col_select,
	output logic [7:0]                   row_data,
	input  logic                         speech_busy,
	// Sound
	input  logic [7:0]                   chip_l,
	input  logic [7:0]                   chip_r,
	input  logic [15:0]                  sample_l,
	input  logic [15:0]                  sample_r,
	output logic [15:0]                  audio_l,
	output logic [15:0]                  audio_r,
	// Video counters and pixel
	input  logic [8:0]                   hcount,
	input  logic [10:0]                  vcount,
	input  astro_pkg::rgb_t              rgb_in,
	output astro_pkg::rgb_t              rgb_out
);
	import astro_pkg::*;

	game_t                            game;
	logic [8*`ASTRO_DIP_BANKS-1:0]    dip;
	player_btn_t                      p1;
	player_btn_t                      p2;
	sys_btn_t                         sys;

	astro_game_config u_game_config (
		.clk_sys, .reset, .cfg_wr, .cfg_index, .cfg_addr, .cfg_data, .game, .dip
	);

	astro_key_capture u_key_capture (
		.clk_sys, .reset, .ps2_key, .joy_p1, .joy_p2, .p1, .p2, .sys
	);

	astro_switch_matrix u_switch_matrix (
		.col_select, .game, .dip, .p1, .p2, .sys, .speech_busy, .row_data
	);

	astro_audio_mix u_audio_mix (
		.clk_sys, .reset, .game, .chip_l, .chip_r, .sample_l, .sample_r, .audio_l, .audio_r
	);

	astro_video_post u_video_post (
		.clk_sys, .reset, .game, .dip, .hcount, .vcount, .rgb_in, .rgb_out
	);

endmodule

/* dv/astro_io_properties.sv */
//==============================
// Concurrent checks on the I/O top level
// Idle rows, edge blanking, key latches in reset
//==============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_io_properties (
	input logic                       clk_sys,
	input logic                       reset,
	input astro_pkg::game_t           game,
	input logic [7:0]                 row_data,
	input logic [8:0]                 hcount,
	input logic [10:0]                vcount,
	input astro_pkg::rgb_t            rgb_out,
	input astro_pkg::player_btn_t     p1,
	input astro_pkg::player_btn_t     p2,
	input astro_pkg::sys_btn_t        sys,
	input logic [`ASTRO_JOY_BITS-1:0] joy_p1,
	input logic [`ASTRO_JOY_BITS-1:0] joy_p2
);
	import astro_pkg::*;

	int          fail_count = 0;
	logic [10:0] line;
	logic        edge_pos;
	player_btn_t joy_btn1;
	player_btn_t joy_btn2;
	sys_btn_t    joy_sys;

	assign line     = (vcount >= `ASTRO_LINE_FOLD) ? vcount - `ASTRO_LINE_SUB : vcount;
	assign edge_pos = (line >= `ASTRO_VBOT) || (line <= `ASTRO_VTOP) || (hcount <= `ASTRO_HLEFT);

	// Joystick share of the buttons, up down left right fire1 fire2
	assign joy_btn1 = {joy_p1[3], joy_p1[2], joy_p1[1], joy_p1[0], joy_p1[4], joy_p1[5]};
	assign joy_btn2 = {joy_p2[3], joy_p2[2], joy_p2[1], joy_p2[0], joy_p2[4], joy_p2[5]};
	assign joy_sys  = {joy_p1[6], joy_p1[7], joy_p1[8]};

	//==============================
	// Assertions
	//==============================
	idle_row: assert property (@(posedge clk_sys) disable iff (reset)
		game == none |-> row_data == `ASTRO_ROW_IDLE)
	else begin
		fail_count++;
		$error("row_data not idle with no game selected");
	end

	edge_black: assert property (@(posedge clk_sys) disable iff (reset)
		edge_pos |=> rgb_out == '0)
	else begin
		fail_count++;
		$error("rgb_out not black after an edge position");
	end

	// Only the joystick can show through while the latches are held
	keys_in_reset: assert property (@(posedge clk_sys)
		reset |-> (p1 == joy_btn1 && p2 == joy_btn2 && sys == joy_sys))
	else begin
		fail_count++;
		$error("key buttons active during reset");
	end

endmodule

bind astro_io_top astro_io_properties u_properties (
	.clk_sys(clk_sys),
	.reset(reset),
	.game(game),
	.row_data(row_data),
	.hcount(hcount),
	.vcount(vcount),
	.rgb_out(rgb_out),
	.p1(p1),
	.p2(p2),
	.sys(sys),
	.joy_p1(joy_p1),
	.joy_p2(joy_p2)
);

/* dv/astro_io_tb.sv */
//==============================
// Testbench for the player I/O glue
// Pattern file checks, random video check
// Watchdog and closing summary
//==============================

`timescale 1ns/100ps

`include "astro_cfg.svh"

module astro_io_tb;
	import astro_pkg::*;

	localparam int CLK_HALF      = 10;
	localparam int RESET_CYCLES  = 8;
	localparam int PATTERN_LIMIT = 64;
	localparam int VIDEO_COUNT   = 200;
	// One clock per step, two video passes, slack for setup writes
	localparam int RUN_CYCLES = RESET_CYCLES + PATTERN_LIMIT + 2 * VIDEO_COUNT + 50;

	logic                       clk_sys = 1'b0;
	logic                       reset;
	logic                       cfg_wr;
	logic [7:0]                 cfg_index;
	logic [2:0]                 cfg_addr;
	logic [7:0]                 cfg_data;
	ps2_key_t                   ps2_key;
	logic [`ASTRO_JOY_BITS-1:0] joy_p1;
	logic [`ASTRO_JOY_BITS-1:0] joy_p2;
	logic [7:0]                 col_select;
	logic [7:0]                 row_data;
	logic                       speech_busy;
	logic [7:0]                 chip_l;
	logic [7:0]                 chip_r;
	logic [15:0]                sample_l;
	logic [15:0]                sample_r;
	logic [15:0]                audio_l;
	logic [15:0]                audio_r;
	logic [8:0]                 hcount;
	logic [10:0]                vcount;
	rgb_t                       rgb_in;
	rgb_t                       rgb_out;

	int          pattern_errors = 0;
	int          video_errors = 0;
	logic [31:0] rnd_state = 32'd97894;
	logic        mono_on = 1'b0;

	astro_io_top u_astro_io_top (
		.clk_sys, .reset, .cfg_wr, .cfg_index, .cfg_addr, .cfg_data, .ps2_key, .joy_p1,
		.joy_p2, .col_select, .row_data, .speech_busy, .chip_l, .chip_r, .sample_l,
		.sample_r, .audio_l, .audio_r, .hcount, .vcount, .rgb_in, .rgb_out
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	//==============================
	// Reference models
	//==============================
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Fold, edge blank, then the mono greys with the last match winning
	function automatic rgb_t predict_pixel(input logic [8:0] h, input logic [10:0] v,
		input rgb_t pix, input logic mono);
		logic [10:0] line;
		rgb_t        result;
		line = (v >= `ASTRO_LINE_FOLD) ? v - `ASTRO_LINE_SUB : v;
		result = pix;
		if (mono && pix.g == 4'd15 && pix.b == 4'd4) begin
			result = {4'd14, 4'd14, 4'd14};
		end
		if (mono && pix.b == 4'd11) begin
			result = {4'd10, 4'd10, 4'd10};
		end
		if (mono && pix.g == 4'd4) begin
			result = {4'd8, 4'd8, 4'd8};
		end
		if (line >= `ASTRO_VBOT || line <= `ASTRO_VTOP || h <= `ASTRO_HLEFT) begin
			result = '0;
		end
		return result;
	endfunction

	//==============================
	// Stimulus tasks, entered on a falling edge
	//==============================
	task automatic write_config(input logic [7:0] index, input logic [2:0] addr,
		input logic [7:0] data);
		cfg_wr    = 1'b1;
		cfg_index = index;
		cfg_addr  = addr;
		cfg_data  = data;
		@(negedge clk_sys);
		cfg_wr = 1'b0;
	endtask

	// New event by flipping the toggle
	task automatic send_key(input logic pressed, input logic [8:0] code);
		ps2_key.toggle  = ~ps2_key.toggle;
		ps2_key.pressed = pressed;
		ps2_key.code    = code;
		@(negedge clk_sys);
	endtask

	task automatic run_pattern(input logic [63:0] op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c, input logic [31:0] d,
		input logic [31:0] expected);
		if (op == "config") begin
			write_config(a[7:0], b[2:0], c[7:0]);
		end else if (op == "key") begin
			send_key(a[0], b[8:0]);
		end else if (op == "joy") begin
			joy_p1 = a[15:0];
			joy_p2 = b[15:0];
			@(negedge clk_sys);
		end else if (op == "row") begin
			col_select  = a[7:0];
			speech_busy = b[0];
			@(negedge clk_sys);
			if (row_data !== expected[7:0]) begin
				pattern_errors++;
				$display("ERR %0t row col %02h expected %02h got %02h", $time, a[7:0],
					expected[7:0], row_data);
			end
		end else if (op == "audio") begin
			chip_l   = a[7:0];
			chip_r   = b[7:0];
			sample_l = c[15:0];
			sample_r = d[15:0];
			// Mixer output is one register deep
			@(negedge clk_sys);
			if (audio_l !== expected[31:16] || audio_r !== expected[15:0]) begin
				pattern_errors++;
				$display("ERR %0t audio expected %08h got %04h%04h", $time, expected,
					audio_l, audio_r);
			end
		end else begin
			pattern_errors++;
			$display("Unknown opcode %0s in the pattern file", op);
		end
	endtask

	task automatic run_video(input int count);
		rgb_t        expected;
		logic [31:0] pix_rnd;
		for (int i = 0; i < count; i++) begin
			rnd_state = next_random(rnd_state);
			hcount = rnd_state[8:0];
			// Range past 263 to reach the second field
			vcount = rnd_state[19:9] % 11'd540;
			pix_rnd   = next_random(rnd_state);
			rnd_state = pix_rnd;
			rgb_in = pix_rnd[11:0];
			// Steer a quarter of pixels onto the first grey rule
			if (pix_rnd[13:12] == 2'b00) begin
				rgb_in.g = 4'd15;
				rgb_in.b = 4'd4;
			end
			expected = predict_pixel(hcount, vcount, rgb_in, mono_on);
			@(negedge clk_sys);
			if (rgb_out !== expected) begin
				video_errors++;
				$display("ERR %0t video h %0d v %0d expected %03h got %03h", $time,
					hcount, vcount, expected, rgb_out);
			end
		end
	endtask

	// Plain code of an extended arrow must leave the player 1 column idle
	// Robby Roto column 04 with nothing pressed reads all ones
	task automatic check_plain_arrow(input logic [8:0] code);
		send_key(1'b1, code);
		run_pattern("row", 32'h04, 32'h0, 32'h0, 32'h0, 32'hff);
		send_key(1'b0, code);
	endtask

	//==============================
	// Main sequence
	//==============================
	initial begin
		int                fd;
		int                count;
		int                n_patterns;
		int                assert_errors;
		logic [8*96-1:0]   line_buf;
		logic [63:0]       op;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       c;
		logic [31:0]       d;
		logic [31:0]       expected;
		reset       = 1'b1;
		cfg_wr      = 1'b0;
		cfg_index   = '0;
		cfg_addr    = '0;
		cfg_data    = '0;
		ps2_key     = '0;
		joy_p1      = '0;
		joy_p2      = '0;
		col_select  = '0;
		speech_busy = 1'b0;
		chip_l      = '0;
		chip_r      = '0;
		sample_l    = '0;
		sample_r    = '0;
		hcount      = '0;
		vcount      = '0;
		rgb_in      = '0;
		n_patterns  = 0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		fd = $fopen("dv/astro_io_patterns.txt", "r");
		if (fd == 0) begin
			pattern_errors++;
			$display("Could not open the pattern file dv/astro_io_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				op       = '0;
				count = $fgets(line_buf, fd);
				count = $sscanf(line_buf, "%s %h %h %h %h %h", op, a, b, c, d, expected);
				// Blank and comment lines carry no command
				if (count > 0 && op != "#") begin
					n_patterns++;
					if (count != 6) begin
						pattern_errors++;
						$display("Pattern %0d has %0d fields instead of 6", n_patterns, count);
					end else begin
						run_pattern(op, a, b, c, d, expected);
					end
				end
			end
			$fclose(fd);
		end
		if (n_patterns > PATTERN_LIMIT) begin
			pattern_errors++;
			$display("Pattern file holds %0d commands, more than the watchdog allows",
				n_patterns);
		end

		// Down, left and right answer only with the extended flag
		write_config(`ASTRO_IDX_GAME, 3'd0, 8'd6);
		joy_p1 = '0;
		check_plain_arrow(9'h072);
		check_plain_arrow(9'h06b);
		check_plain_arrow(9'h074);

		// Space Zap with mono on, then off
		write_config(`ASTRO_IDX_GAME, 3'd0, 8'd3);
		write_config(`ASTRO_IDX_DIP, 3'd0, 8'h02);
		mono_on = 1'b1;
		run_video(VIDEO_COUNT);
		write_config(`ASTRO_IDX_DIP, 3'd0, 8'h00);
		mono_on = 1'b0;
		run_video(VIDEO_COUNT);

		assert_errors = u_astro_io_top.u_properties.fail_count;
		$display("Error counts: pattern %0d, video %0d, assertion %0d", pattern_errors,
			video_errors, assert_errors);
		if (pattern_errors == 0 && video_errors == 0 && assert_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_CYCLES * 2 * CLK_HALF);
		$display("Timeout: run did not finish within %0d clock cycles", RUN_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* dv/astro_io_patterns.txt */
# op a b c d expected, all hex, unused fields 0
# config idx addr data, key pressed code, joy p1 p2, row col busy, audio chl chr sml smr
row 01 0 0 0 ff
row 04 0 0 0 ff
row 08 0 0 0 ff
audio 12 34 1000 2000 12121212
config 01 0 03 0 0
config fe 2 03 0 0
row 01 0 0 0 ff
key 1 175 0 0 0
key 1 014 0 0 0
row 04 0 0 0 ee
key 0 075 0 0 0
row 04 0 0 0 ef
key 0 014 0 0 0
joy 0001 0000 0 0 0
key 1 174 0 0 0
key 0 174 0 0 0
row 04 0 0 0 f7
joy 0140 0000 0 0 0
row 01 0 0 0 ed
key 1 02d 0 0 0
row 02 0 0 0 fe
key 0 02d 0 0 0
audio a5 3c 0 0 a5a5a5a5
config 01 0 05 0 0
config fe 3 5a 0 0
joy 0000 0020 0 0 0
row 01 0 0 0 7f
row 02 0 0 0 ff
row 04 1 0 0 ef
row 08 0 0 0 5a
audio 80 ff 1000 fffc 24207ffe
config 01 0 06 0 0
joy 0000 0011 0 0 0
row 01 0 0 0 7f
row 02 0 0 0 d7
audio 12 34 0 0 12123434

/* sources.f */
+incdir+design
design/astro_pkg.sv
design/astro_game_config.sv
design/astro_key_capture.sv
design/astro_switch_matrix.sv
design/astro_audio_mix.sv
design/astro_video_post.sv
design/astro_io_top.sv
dv/astro_io_properties.sv
dv/astro_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the player I/O testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module astro_io_tb -Mdir obj_dir

out=$(./obj_dir/Vastro_io_tb +verilator+error+limit+100000 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "^Simulation PASSED$"; then
	exit 0
else
	exit 1
fi
